/* run_sim.sh */
#!/bin/sh
# Compile and run the CSR unit testbench with Verilator.
# The exit status is the simulator's own: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_unit \
    -f tb.f \
    --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit $status
fi

./obj_dir/Vtb_csr_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* source/csr_decode.sv */
`timescale 1ns/100ps

module csr_decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  csr_pkg::cmd_t            cmd,
    input  logic [csr_pkg::XLEN-1:0] op1,
    input  logic [csr_pkg::XLEN-1:0] imm,
    input  logic [csr_pkg::XLEN-1:0] pc,
    input  logic                     flush,
    output csr_pkg::cmd_t            d_cmd,
    output logic [11:0]              d_addr,
    output logic [csr_pkg::XLEN-1:0] d_op1,
    output logic [csr_pkg::XLEN-1:0] d_pc
);

    // Command register with flushed slots turned into bubbles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d_cmd <= csr_pkg::CMD_NONE;
        end else if (flush || cmd == csr_pkg::CMD_SRET) begin
            // sret unsupported and run as a nop
            d_cmd <= csr_pkg::CMD_NONE;
        end else begin
            d_cmd <= cmd;
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        // CSR number sits in the I-type immediate
        d_addr <= imm[11:0];
        d_op1  <= op1;
        d_pc   <= pc;
    end

    // Only legal codes reach execute once out of reset
    a_cmd_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(d_cmd) && d_cmd inside {csr_pkg::CMD_NONE, csr_pkg::CMD_W,
                                            csr_pkg::CMD_S, csr_pkg::CMD_C,
                                            csr_pkg::CMD_ECALL, csr_pkg::CMD_MRET});

endmodule

/* source/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  csr_pkg::cmd_t            d_cmd,
    input  logic [11:0]              d_addr,
    input  logic [csr_pkg::XLEN-1:0] d_op1,
    input  logic [csr_pkg::XLEN-1:0] d_pc,
    input  logic [63:0]              cycle,
    input  logic [63:0]              mtime,
    input  logic [63:0]              mtimecmp,
    input  logic                     interrupt_ready,
    output logic [csr_pkg::XLEN-1:0] x_rdata,
    output csr_pkg::cmd_t            x_cmd,
    output logic                     x_trap,
    output logic [csr_pkg::XLEN-1:0] x_vector,
    output logic                     irq_stall
);

    csr_pkg::mode_t mode;

    // Implemented machine CSRs
    logic [csr_pkg::XLEN-1:0] mstatus;
    logic [csr_pkg::XLEN-1:0] mstatush;
    logic [csr_pkg::XLEN-1:0] medeleg;
    logic [csr_pkg::XLEN-1:0] mie;
    logic [csr_pkg::XLEN-1:0] mtvec;
    logic [csr_pkg::XLEN-1:0] mscratch;
    logic [csr_pkg::XLEN-1:0] mepc;
    logic [csr_pkg::XLEN-1:0] mcause;
    logic [csr_pkg::XLEN-1:0] mtval;
    logic [csr_pkg::XLEN-1:0] mip;
    logic                     mideleg_mtie;

    logic                     timer_due;
    logic                     take_irq;
    logic                     trap_entry;
    logic                     is_mret;
    logic                     csr_op;
    logic [csr_pkg::XLEN-1:0] trap_cause;
    logic [csr_pkg::XLEN-1:0] rd_value;
    logic [csr_pkg::XLEN-1:0] wdata;
    logic [csr_pkg::XLEN-1:0] mstatus_wr;
    logic [1:0]               mpp;

    assign mpp = mstatus[csr_pkg::MSTATUS_MPP_LO +: 2];

    // Timer interrupt taken only for M with global enable and no delegation
    assign timer_due = mtime >= mtimecmp;
    assign irq_stall = timer_due && mie[csr_pkg::MIE_MTIE] && !mideleg_mtie
                       && mode == csr_pkg::MODE_M && mstatus[csr_pkg::MSTATUS_MIE];
    assign take_irq  = irq_stall && interrupt_ready;

    // Interrupt wins over whatever sits in execute
    assign trap_entry = take_irq || d_cmd == csr_pkg::CMD_ECALL;
    assign is_mret    = !take_irq && d_cmd == csr_pkg::CMD_MRET;
    assign csr_op     = !take_irq && d_cmd inside {csr_pkg::CMD_W, csr_pkg::CMD_S,
                                                   csr_pkg::CMD_C};
    // Ecall cause is 8 plus the current mode
    assign trap_cause = take_irq ? csr_pkg::CAUSE_TIMER
                      : csr_pkg::CAUSE_ECALL_BASE + {{(csr_pkg::XLEN-2){1'b0}}, mode};

    // Old value by address with unknown addresses reading 0
    always_comb begin
        case (d_addr)
            csr_pkg::ADDR_MSTATUS:  rd_value = mstatus;
            csr_pkg::ADDR_MSTATUSH: rd_value = mstatush;
            csr_pkg::ADDR_MEDELEG:  rd_value = medeleg;
            csr_pkg::ADDR_MIDELEG:  rd_value = {{(csr_pkg::XLEN-1){1'b0}}, mideleg_mtie}
                                               << csr_pkg::MIE_MTIE;
            csr_pkg::ADDR_MIE:      rd_value = mie;
            csr_pkg::ADDR_MTVEC:    rd_value = mtvec;
            csr_pkg::ADDR_MSCRATCH: rd_value = mscratch;
            csr_pkg::ADDR_MEPC:     rd_value = mepc;
            csr_pkg::ADDR_MCAUSE:   rd_value = mcause;
            csr_pkg::ADDR_MTVAL:    rd_value = mtval;
            // MTIP mirrors the live compare
            csr_pkg::ADDR_MIP:      rd_value = mip | ({{(csr_pkg::XLEN-1){1'b0}}, timer_due}
                                               << csr_pkg::MIE_MTIE);
            csr_pkg::ADDR_CYCLE:    rd_value = cycle[31:0];
            csr_pkg::ADDR_CYCLEH:   rd_value = cycle[63:32];
            csr_pkg::ADDR_TIME:     rd_value = mtime[31:0];
            csr_pkg::ADDR_TIMEH:    rd_value = mtime[63:32];
            default:                rd_value = '0;
        endcase
    end

    // Write, set and clear data
    always_comb begin
        case (d_cmd)
            csr_pkg::CMD_W: wdata = d_op1;
            csr_pkg::CMD_S: wdata = rd_value | d_op1;
            csr_pkg::CMD_C: wdata = rd_value & ~d_op1;
            default:        wdata = rd_value;
        endcase
    end

    // MPP is WARL and the reserved encoding keeps the old field
    always_comb begin
        mstatus_wr = wdata;
        if (wdata[csr_pkg::MSTATUS_MPP_LO +: 2] == 2'b10) begin
            mstatus_wr[csr_pkg::MSTATUS_MPP_LO +: 2] = mpp;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode         <= csr_pkg::MODE_M;
            mstatus      <= '0;
            mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] <= csr_pkg::MODE_M;
            mstatush     <= '0;
            medeleg      <= '0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mip          <= '0;
            mideleg_mtie <= 1'b0;
        end else if (trap_entry) begin
            // Ecall or timer interrupt into M
            mcause <= trap_cause;
            mepc   <= d_pc;
            mstatus[csr_pkg::MSTATUS_MPIE]        <= mstatus[csr_pkg::MSTATUS_MIE];
            mstatus[csr_pkg::MSTATUS_MIE]         <= 1'b0;
            mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] <= mode;
            mode   <= csr_pkg::MODE_M;
        end else if (is_mret) begin
            mode <= csr_pkg::mode_t'(mpp);
            mstatus[csr_pkg::MSTATUS_MIE]         <= mstatus[csr_pkg::MSTATUS_MPIE];
            mstatus[csr_pkg::MSTATUS_MPIE]        <= 1'b1;
            mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] <= csr_pkg::MODE_U;
            // Leaving M drops modified privilege
            if (mpp != csr_pkg::MODE_M) begin
                mstatus[csr_pkg::MSTATUS_MPRV] <= 1'b0;
            end
        end else if (csr_op) begin
            case (d_addr)
                csr_pkg::ADDR_MSTATUS:  mstatus      <= mstatus_wr;
                csr_pkg::ADDR_MSTATUSH: mstatush     <= wdata;
                csr_pkg::ADDR_MEDELEG:  medeleg      <= wdata;
                csr_pkg::ADDR_MIDELEG:  mideleg_mtie <= wdata[csr_pkg::MIE_MTIE];
                csr_pkg::ADDR_MIE:      mie          <= wdata;
                csr_pkg::ADDR_MTVEC:    mtvec        <= wdata;
                csr_pkg::ADDR_MSCRATCH: mscratch     <= wdata;
                csr_pkg::ADDR_MEPC:     mepc         <= wdata;
                csr_pkg::ADDR_MCAUSE:   mcause       <= wdata;
                csr_pkg::ADDR_MTVAL:    mtval        <= wdata;
                // MTIP is not software writable
                csr_pkg::ADDR_MIP: begin
                    mip <= wdata & ~({{(csr_pkg::XLEN-1){1'b0}}, 1'b1} << csr_pkg::MIE_MTIE);
                end
                default: begin
                end
            endcase
        end
    end

    // Execute results where a dropped command reads 0
    assign x_cmd    = take_irq ? csr_pkg::CMD_ECALL : d_cmd;
    assign x_trap   = trap_entry || is_mret;
    assign x_rdata  = csr_op ? rd_value : '0;
    assign x_vector = trap_entry ? mtvec : (is_mret ? mepc : '0);

    a_mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        mode != 2'b10);

    // Trap only from ecall, mret or a timer that has reached its compare
    a_trap_source: assert property (@(posedge clk) disable iff (!arst_n)
        x_trap |-> d_cmd inside {csr_pkg::CMD_ECALL, csr_pkg::CMD_MRET}
                   || (mtime >= mtimecmp && interrupt_ready));

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

    // Data path width
    parameter int XLEN = 32;

    // CSR commands from the decoder of the core
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5,
        CMD_SRET  = 3'd6
    } cmd_t;

    // Privilege modes, 2'b10 is reserved
    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_S = 2'b01,
        MODE_M = 2'b11
    } mode_t;

    // Machine trap setup
    parameter logic [11:0] ADDR_MSTATUS  = 12'h300;
    parameter logic [11:0] ADDR_MEDELEG  = 12'h302;
    parameter logic [11:0] ADDR_MIDELEG  = 12'h303;
    parameter logic [11:0] ADDR_MIE      = 12'h304;
    parameter logic [11:0] ADDR_MTVEC    = 12'h305;
    parameter logic [11:0] ADDR_MSTATUSH = 12'h310;

    // Machine trap handling
    parameter logic [11:0] ADDR_MSCRATCH = 12'h340;
    parameter logic [11:0] ADDR_MEPC     = 12'h341;
    parameter logic [11:0] ADDR_MCAUSE   = 12'h342;
    parameter logic [11:0] ADDR_MTVAL    = 12'h343;
    parameter logic [11:0] ADDR_MIP      = 12'h344;

    // User counters, read only
    parameter logic [11:0] ADDR_CYCLE    = 12'hc00;
    parameter logic [11:0] ADDR_TIME     = 12'hc01;
    parameter logic [11:0] ADDR_CYCLEH   = 12'hc80;
    parameter logic [11:0] ADDR_TIMEH    = 12'hc81;

    // mstatus fields
    parameter int MSTATUS_MIE    = 3;
    parameter int MSTATUS_MPIE   = 7;
    parameter int MSTATUS_MPP_LO = 11;
    parameter int MSTATUS_MPRV   = 17;

    // Timer bit in mie, mip and mideleg
    parameter int MIE_MTIE = 7;

    // Trap causes
    parameter logic [XLEN-1:0] CAUSE_TIMER      = 32'h8000_0007;
    parameter logic [XLEN-1:0] CAUSE_ECALL_BASE = 32'd8;

endpackage

/* source/csr_result.sv */
`timescale 1ns/100ps

module csr_result (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [csr_pkg::XLEN-1:0] x_rdata,
    input  csr_pkg::cmd_t            x_cmd,
    input  logic                     x_trap,
    input  logic [csr_pkg::XLEN-1:0] x_vector,
    output logic [csr_pkg::XLEN-1:0] rdata,
    output csr_pkg::cmd_t            cmd_out,
    output logic                     trap_taken,
    output logic [csr_pkg::XLEN-1:0] trap_vector
);

    // Result register toward the core
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata       <= '0;
            cmd_out     <= csr_pkg::CMD_NONE;
            trap_taken  <= 1'b0;
            trap_vector <= '0;
        end else begin
            rdata      <= x_rdata;
            cmd_out    <= x_cmd;
            trap_taken <= x_trap;
            // Vector held until the next trap
            if (x_trap) begin
                trap_vector <= x_vector;
            end
        end
    end

    // Every trap strobe comes with a trap command
    a_trap_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        trap_taken |-> cmd_out inside {csr_pkg::CMD_ECALL, csr_pkg::CMD_MRET});

endmodule

/* source/csr_unit.sv */
`timescale 1ns/100ps

module csr_unit #(
    parameter int MTIME_DIV = 4
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  csr_pkg::cmd_t            cmd,
    input  logic [csr_pkg::XLEN-1:0] op1,
    input  logic [csr_pkg::XLEN-1:0] imm,
    input  logic [csr_pkg::XLEN-1:0] pc,
    input  logic                     flush,
    input  logic                     interrupt_ready,
    input  logic [63:0]              mtimecmp,
    output logic [csr_pkg::XLEN-1:0] rdata,
    output csr_pkg::cmd_t            cmd_out,
    output logic                     trap_taken,
    output logic [csr_pkg::XLEN-1:0] trap_vector,
    output logic                     irq_stall
);

    // Decode to execute
    csr_pkg::cmd_t            d_cmd;
    logic [11:0]              d_addr;
    logic [csr_pkg::XLEN-1:0] d_op1;
    logic [csr_pkg::XLEN-1:0] d_pc;

    // Timer counters
    logic [63:0]              cycle;
    logic [63:0]              mtime;

    // Execute to result
    logic [csr_pkg::XLEN-1:0] x_rdata;
    csr_pkg::cmd_t            x_cmd;
    logic                     x_trap;
    logic [csr_pkg::XLEN-1:0] x_vector;

    csr_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (cmd),
        .op1    (op1),
        .imm    (imm),
        .pc     (pc),
        .flush  (flush),
        .d_cmd  (d_cmd),
        .d_addr (d_addr),
        .d_op1  (d_op1),
        .d_pc   (d_pc)
    );

    mtimer #(
        .MTIME_DIV (MTIME_DIV)
    ) u_mtimer (
        .clk    (clk),
        .arst_n (arst_n),
        .cycle  (cycle),
        .mtime  (mtime)
    );

    csr_file u_file (
        .clk             (clk),
        .arst_n          (arst_n),
        .d_cmd           (d_cmd),
        .d_addr          (d_addr),
        .d_op1           (d_op1),
        .d_pc            (d_pc),
        .cycle           (cycle),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .interrupt_ready (interrupt_ready),
        .x_rdata         (x_rdata),
        .x_cmd           (x_cmd),
        .x_trap          (x_trap),
        .x_vector        (x_vector),
        .irq_stall       (irq_stall)
    );

    csr_result u_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .x_rdata     (x_rdata),
        .x_cmd       (x_cmd),
        .x_trap      (x_trap),
        .x_vector    (x_vector),
        .rdata       (rdata),
        .cmd_out     (cmd_out),
        .trap_taken  (trap_taken),
        .trap_vector (trap_vector)
    );

endmodule

/* source/mtimer.sv */
`timescale 1ns/100ps

module mtimer #(
    parameter int MTIME_DIV = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic [63:0] cycle,
    output logic [63:0] mtime
);

    // Prescaler needs at least one bit even for a divide by 1
    localparam int PW = (MTIME_DIV > 1) ? $clog2(MTIME_DIV) : 1;
    localparam logic [PW-1:0] PRESC_LAST = PW'(MTIME_DIV - 1);

    logic [PW-1:0] presc;

    // Clock cycle count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // mtime advances once per MTIME_DIV clocks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc <= '0;
            mtime <= '0;
        end else if (presc == PRESC_LAST) begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // mtime locked to the cycle count and so never stepping back
    a_mtime_tracks_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        mtime == cycle / 64'(MTIME_DIV));

endmodule

/* tb.f */
source/csr_pkg.sv
source/csr_decode.sv
source/mtimer.sv
source/csr_file.sv
source/csr_result.sv
source/csr_unit.sv
testbench/clock_gen.sv
testbench/tb_csr_unit.sv

/* testbench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic arst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Reset low for two clock periods, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* testbench/csr_patterns.txt */
# name cmd addr op1 pc flush exp_rdata exp_trap exp_vector, all hex apart from name
# cmd 0 none 1 write 2 set 3 clear 4 ecall 5 mret 6 sret, vector checked when trap is 1
w_mscratch        1 340 12345678 00000000 0 00000000 0 00000000
rd_mscratch       2 340 00000000 00000000 0 12345678 0 00000000
set_mscratch      2 340 0000f000 00000000 0 12345678 0 00000000
clr_mscratch      3 340 00000078 00000000 0 1234f678 0 00000000
rd_mscratch2      2 340 00000000 00000000 0 1234f600 0 00000000
w_mtvec           1 305 00000100 00000000 0 00000000 0 00000000
set_mtvec         2 305 00000080 00000000 0 00000100 0 00000000
clr_mtvec         3 305 00000100 00000000 0 00000180 0 00000000
w_mtvec2          1 305 00000200 00000000 0 00000080 0 00000000
w_mepc            1 341 00001000 00000000 0 00000000 0 00000000
set_mepc          2 341 00000004 00000000 0 00001000 0 00000000
clr_mepc          3 341 00001000 00000000 0 00001004 0 00000000
rd_mepc           2 341 00000000 00000000 0 00000004 0 00000000
flush_mscratch    1 340 deadbeef 00000000 1 00000000 0 00000000
rd_after_flush    2 340 00000000 00000000 0 1234f600 0 00000000
w_cycleh          1 c80 ffffffff 00000000 0 00000000 0 00000000
rd_cycleh         2 c80 00000000 00000000 0 00000000 0 00000000
w_unimpl          1 7c0 aaaaaaaa 00000000 0 00000000 0 00000000
rd_unimpl         2 7c0 00000000 00000000 0 00000000 0 00000000
rd_mstatus        2 300 00000000 00000000 0 00001800 0 00000000
ecall_m           4 000 00000000 00000400 0 00000000 1 00000200
rd_mcause         2 342 00000000 00000000 0 0000000b 0 00000000
rd_mepc_ecall     2 341 00000000 00000000 0 00000400 0 00000000
rd_mstatus_ecall  2 300 00000000 00000000 0 00001800 0 00000000
w_mstatus_mpp_u   1 300 00000080 00000000 0 00001800 0 00000000
w_mepc_ret        1 341 00000800 00000000 0 00000400 0 00000000
mret              5 000 00000000 00000000 0 00000000 1 00000800
rd_mstatus_mret   2 300 00000000 00000000 0 00000088 0 00000000
ecall_u           4 000 00000000 00000900 0 00000000 1 00000200
rd_mcause_u       2 342 00000000 00000000 0 00000008 0 00000000
rd_mstatus_u      2 300 00000000 00000000 0 00000080 0 00000000
sret_nop          6 000 00000000 00000000 0 00000000 0 00000000

/* testbench/tb_csr_unit.sv */
`timescale 1ns/100ps

module tb_csr_unit;

    localparam int MTIME_DIV  = 4;
    localparam int WAIT_LIMIT = 500;

    logic          clk;
    logic          arst_n;
    csr_pkg::cmd_t cmd;
    logic [31:0]   op1;
    logic [31:0]   imm;
    logic [31:0]   pc;
    logic          flush;
    logic          interrupt_ready;
    logic [63:0]   mtimecmp;
    logic [31:0]   rdata;
    csr_pkg::cmd_t cmd_out;
    logic          trap_taken;
    logic [31:0]   trap_vector;
    logic          irq_stall;

    // Expected results waiting out the two edge latency
    logic [191:0]  exp_name[$];
    logic [31:0]   exp_rdata[$];
    logic          exp_trap[$];
    logic [31:0]   exp_vector[$];

    // Rising edge count, read on falling edges only
    int            tick = 0;
    int            drive_tick = 0;

    clock_gen u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    csr_unit #(
        .MTIME_DIV (MTIME_DIV)
    ) DUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd             (cmd),
        .op1             (op1),
        .imm             (imm),
        .pc              (pc),
        .flush           (flush),
        .interrupt_ready (interrupt_ready),
        .mtimecmp        (mtimecmp),
        .rdata           (rdata),
        .cmd_out         (cmd_out),
        .trap_taken      (trap_taken),
        .trap_vector     (trap_vector),
        .irq_stall       (irq_stall)
    );

    always @(posedge clk) begin
        tick <= tick + 1;
    end

    task automatic check_value(input logic [191:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s expected %08h actual %08h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic drive_inputs(input logic [2:0] code, input logic [11:0] addr,
                                input logic [31:0] operand, input logic [31:0] pc_value,
                                input logic flush_value);
        cmd   = csr_pkg::cmd_t'(code);
        // CSR number as a sign extended I-type immediate
        imm   = {{20{addr[11]}}, addr};
        op1   = operand;
        pc    = pc_value;
        flush = flush_value;
    endtask

    // One command alone in the pipe, old value returned
    task automatic issue_command(input logic [2:0] code, input logic [11:0] addr,
                                 input logic [31:0] operand, output logic [31:0] result);
        @(negedge clk);
        drive_inputs(code, addr, operand, 32'h0, 1'b0);
        drive_tick = tick;
        @(negedge clk);
        drive_inputs(3'd0, 12'h000, 32'h0, 32'h0, 1'b0);
        @(negedge clk);
        result = rdata;
    endtask

    task automatic check_oldest();
        logic [191:0] name;
        logic [31:0]  value;
        logic         trap;
        logic [31:0]  vector;
        name   = exp_name.pop_front();
        value  = exp_rdata.pop_front();
        trap   = exp_trap.pop_front();
        vector = exp_vector.pop_front();
        check_value(name, value, rdata);
        check_value(name, {31'h0, trap}, {31'h0, trap_taken});
        // Vector only meaningful on a trap
        if (trap) begin
            check_value(name, vector, trap_vector);
        end
    endtask

    // Back to back commands from the pattern file, one per cycle
    task automatic run_patterns();
        int           fd;
        int           n;
        int           count;
        string        line;
        logic [191:0] name;
        logic [31:0]  code;
        logic [31:0]  addr;
        logic [31:0]  operand;
        logic [31:0]  pc_value;
        logic [31:0]  flush_value;
        logic [31:0]  value;
        logic [31:0]  trap;
        logic [31:0]  vector;
        count = 0;
        fd = $fopen("testbench/csr_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open testbench/csr_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, code, addr, operand,
                            pc_value, flush_value, value, trap, vector);
                if (n != 9) begin
                    abort_run({"malformed pattern line: ", line});
                end
                @(negedge clk);
                if (exp_name.size() == 2) begin
                    check_oldest();
                end
                drive_inputs(code[2:0], addr[11:0], operand, pc_value, flush_value[0]);
                exp_name.push_back(name);
                exp_rdata.push_back(value);
                exp_trap.push_back(trap[0]);
                exp_vector.push_back(vector);
                count++;
            end
        end
        $fclose(fd);
        if (count == 0) begin
            abort_run("pattern file holds no patterns");
        end
        // Drain the last two
        while (exp_name.size() > 0) begin
            @(negedge clk);
            check_oldest();
            drive_inputs(3'd0, 12'h000, 32'h0, 32'h0, 1'b0);
        end
    endtask

    task automatic check_timer_irq();
        logic [31:0] value;
        int          waited;
        issue_command(3'd1, 12'h305, 32'h0000_0300, value);
        issue_command(3'd2, 12'h304, 32'h0000_0080, value);
        issue_command(3'd2, 12'h300, 32'h0000_0008, value);
        // Compare at maximum, no request yet
        repeat (4) begin
            @(negedge clk);
            check_value("irq_stall_idle", 32'h0, {31'h0, irq_stall});
        end
        mtimecmp = 64'd20;
        waited = 0;
        while (irq_stall !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("irq_stall did not rise after mtimecmp was lowered");
            end
            @(negedge clk);
            waited++;
        end
        interrupt_ready = 1'b1;
        waited = 0;
        while (trap_taken !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("trap_taken did not pulse for the timer interrupt");
            end
            @(negedge clk);
            waited++;
        end
        check_value("irq_cmd_out", {29'h0, csr_pkg::CMD_ECALL}, {29'h0, cmd_out});
        check_value("irq_vector", 32'h0000_0300, trap_vector);
        // mstatus.mie cleared on entry
        check_value("irq_stall_cleared", 32'h0, {31'h0, irq_stall});
        interrupt_ready = 1'b0;
        issue_command(3'd2, 12'h342, 32'h0, value);
        check_value("irq_mcause", 32'h8000_0007, value);
    endtask

    task automatic check_counters();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] time_now;
        int          first_tick;
        issue_command(3'd2, 12'hc00, 32'h0, first);
        first_tick = drive_tick;
        repeat (10) @(negedge clk);
        issue_command(3'd2, 12'hc00, 32'h0, second);
        check_value("cycle_rising", 32'h1, {31'h0, second > first});
        check_value("cycle_gap", 32'h1,
                    {31'h0, (second - first) >= 32'(drive_tick - first_tick)});
        // time read first, so a later cycle bounds it
        issue_command(3'd2, 12'hc01, 32'h0, time_now);
        issue_command(3'd2, 12'hc00, 32'h0, second);
        check_value("time_bound", 32'h1,
                    {31'h0, time_now <= second / MTIME_DIV + 32'd1});
    endtask

    initial begin
        int waited;
        cmd             = csr_pkg::CMD_NONE;
        op1             = 32'h0;
        imm             = 32'h0;
        pc              = 32'h0;
        flush           = 1'b0;
        interrupt_ready = 1'b0;
        mtimecmp        = '1;
        waited          = 0;
        while (arst_n !== 1'b1) begin
            if (waited == 10) begin
                abort_run("reset was never released");
            end
            @(negedge clk);
            waited++;
        end
        check_value("reset_rdata", 32'h0, rdata);
        check_value("reset_trap", 32'h0, {31'h0, trap_taken});
        check_value("reset_cmd_out", {29'h0, csr_pkg::CMD_NONE}, {29'h0, cmd_out});
        run_patterns();
        check_timer_irq();
        check_counters();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
